// ==== files.f ====
src/exePkg.sv
src/exeReg.sv
src/alu.sv
src/branchSolve.sv
src/mulDiv.sv
src/hiLo.sv
src/exceptExe.sv
src/exeStage.sv
testbench/tbExeStage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench, pass only if the log says so
rm -f sim.log
verilator --binary --timing -f files.f --top-module tbExeStage -o simExe &&
    (./obj_dir/simExe > sim.log 2>&1 || true) &&
    grep -q "^STATUS: PASS$" sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }

// ==== src/alu.sv ====
// Execute stage ALU
// Picks the operands, computes the logic, arithmetic and shift
// operations and flags signed overflow of add and sub
module alu import exePkg::*; (
    input  idExeT       exeIn,
    output logic [31:0] aluOut,
    output logic        overflow
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shamt;

    assign opA   = exeIn.aluSrcA ? {27'b0, exeIn.instr[10:6]} : exeIn.busA;
    assign opB   = exeIn.aluSrcB ? exeIn.imm32 : exeIn.busB;
    assign shamt = opA[4:0];   // sa field or rs for variable shifts
    assign sum   = opA + opB;
    assign diff  = opA - opB;

    always_comb begin
        overflow = 1'b0;
        case (exeIn.aluOp)
            aluAdd: begin
                aluOut   = sum;
                overflow = (opA[31] == opB[31]) && (sum[31] != opA[31]);
            end
            aluAddu: aluOut = sum;
            aluSub: begin
                aluOut   = diff;
                overflow = (opA[31] != opB[31]) && (diff[31] != opA[31]);
            end
            aluSubu: aluOut = diff;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluXor:  aluOut = opA ^ opB;
            aluNor:  aluOut = ~(opA | opB);
            aluSlt:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
            aluSltu: aluOut = {31'b0, opA < opB};
            aluSll:  aluOut = opB << shamt;
            aluSrl:  aluOut = opB >> shamt;
            aluSra:  aluOut = $signed(opB) >>> shamt;
            aluLui:  aluOut = {opB[15:0], 16'b0};
            default: aluOut = '0;   // mult/div and bubbles
        endcase
    end

endmodule

// ==== src/branchSolve.sv ====
// Branch resolution
// Evaluates the branch condition and raises the front-end flush
module branchSolve import exePkg::*; (
    input  idExeT exeIn,
    output logic  branchFlush
);

    logic aZero;
    logic aNeg;

    assign aZero = (exeIn.busA == '0);
    assign aNeg  = exeIn.busA[31];

    always_comb begin
        case (exeIn.branch)
            brEq:    branchFlush = (exeIn.busA == exeIn.busB);
            brNe:    branchFlush = (exeIn.busA != exeIn.busB);
            brLez:   branchFlush = aNeg || aZero;
            brGtz:   branchFlush = !aNeg && !aZero;
            brLtz:   branchFlush = aNeg;
            brGez:   branchFlush = !aNeg;
            brJump:  branchFlush = 1'b1;   // always taken
            default: branchFlush = 1'b0;
        endcase
    end

endmodule

// ==== src/exceptExe.sv ====
// Execute stage exception detection
// Adds overflow and data address alignment faults to the decode flags
module exceptExe import exePkg::*; (
    input  idExeT      exeIn,
    input  logic       overflow,
    input  logic [1:0] addrLow,
    output exceptT     exceptOut
);

    logic wordBad;
    logic halfBad;

    assign wordBad = (addrLow != 2'b00);
    assign halfBad = addrLow[0];

    always_comb begin
        exceptOut          = exeIn.except;   // rsvd, syscall, break pass on
        exceptOut.overflow = overflow;
        exceptOut.loadAddr = (exeIn.load == ldWord && wordBad)
                          || (exeIn.load == ldHalf && halfBad);
        exceptOut.storeAddr = (exeIn.store == stWord && wordBad)
                           || (exeIn.store == stHalf && halfBad);
    end

endmodule

// ==== src/exePkg.sv ====
// Execute stage package
// Operation encodings, pipeline structs and width constants shared by
// every block of the MIPS32 execute stage
package exePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;   // $ra

    typedef enum logic [4:0] {
        aluAdd, aluAddu, aluSub, aluSubu,
        aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluLui,
        aluMult, aluMultu, aluDiv, aluDivu,
        aluNone = 5'h1f
    } aluOpT;

    typedef enum logic [2:0] {
        brNone, brEq, brNe, brLez, brGtz, brLtz, brGez, brJump
    } branchT;

    typedef enum logic [1:0] {ldNone, ldByte, ldHalf, ldWord} loadT;
    typedef enum logic [1:0] {stNone, stByte, stHalf, stWord} storeT;
    typedef enum logic [1:0] {wbPcPlus8, wbAluOut, wbOutB} wbSelT;
    typedef enum logic [1:0] {dstRd, dstRt, dstLink} dstSelT;
    typedef enum logic [1:0] {rdBusB, rdHi, rdLo} readSelT;

    typedef struct packed {
        logic gpr;
        logic hi;
        logic lo;
    } regsWrT;

    typedef struct packed {
        logic rsvdInstr;   // from decode
        logic syscall;
        logic brk;
        logic overflow;    // raised in execute
        logic loadAddr;
        logic storeAddr;
    } exceptT;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    instr;
        logic [dataWidth-1:0]    busA;
        logic [dataWidth-1:0]    busB;
        logic [dataWidth-1:0]    imm32;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        aluOpT                   aluOp;
        branchT                  branch;
        loadT                    load;
        storeT                   store;
        regsWrT                  regsWr;
        wbSelT                   wbSel;
        dstSelT                  dstSel;
        readSelT                 readSel;
        logic                    aluSrcA;   // shamt as A
        logic                    aluSrcB;   // imm32 as B
        exceptT                  except;
    } idExeT;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    instr;
        logic [dataWidth-1:0]    aluOut;
        logic [dataWidth-1:0]    outB;
        logic [dataWidth-1:0]    result;    // forwarding value
        logic [regAddrWidth-1:0] dst;
        loadT                    load;
        storeT                   store;
        regsWrT                  regsWr;
        exceptT                  except;
    } exeMemT;

    // empty slot in the stage
    localparam idExeT idBubble = '{
        aluOp:   aluNone,
        branch:  brNone,
        load:    ldNone,
        store:   stNone,
        wbSel:   wbPcPlus8,
        dstSel:  dstRd,
        readSel: rdBusB,
        default: '0
    };

endpackage

// ==== src/exeReg.sv ====
// Decode to execute pipeline register
// Loads the decoded instruction on write enable and a bubble on flush
module exeReg import exePkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  exeWr,
    input  logic  exeFlush,
    input  idExeT idBus,
    output idExeT exeIn
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exeIn <= idBubble;
        end else if (exeFlush) begin       // flush wins over write
            exeIn <= idBubble;
        end else if (exeWr) begin
            exeIn <= idBus;
        end
    end

endmodule

// ==== src/exeStage.sv ====
// MIPS32 execute stage top
// Pipeline register, ALU, branch resolution, multiply/divide, HI/LO and
// exception detection, plus the result and destination for memory
module exeStage import exePkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   exeWr,
    input  logic   exeFlush,
    input  logic   exeDisWr,
    input  idExeT  idBus,
    output exeMemT exeBus,
    output logic   branchFlush,
    output logic   mulDivStall
);

    idExeT       exeIn;
    exceptT      exceptOut;
    logic [31:0] aluOut;
    logic [31:0] hiOut;
    logic [31:0] loOut;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] outB;
    logic        overflow;
    logic        done;

    exeReg i_exeReg (.clk, .arstN, .exeWr, .exeFlush, .idBus, .exeIn);

    alu i_alu (.exeIn, .aluOut, .overflow);

    branchSolve i_branchSolve (.exeIn, .branchFlush);

    mulDiv i_mulDiv (
        .clk, .arstN, .exeWr, .exeFlush, .exeIn,
        .mulDivStall, .done, .hiOut, .loOut
    );

    hiLo i_hiLo (
        .clk, .arstN, .done,
        .regsWr (exeIn.regsWr),
        .disWr  (exeDisWr),
        .busA   (exeIn.busA),
        .hiIn   (hiOut),
        .loIn   (loOut),
        .hi, .lo
    );

    exceptExe i_exceptExe (
        .exeIn, .overflow,
        .addrLow   (aluOut[1:0]),   // data address from the ALU
        .exceptOut
    );

    always_comb begin
        case (exeIn.readSel)
            rdHi:    outB = hi;   // mfhi
            rdLo:    outB = lo;   // mflo
            default: outB = exeIn.busB;
        endcase

        exeBus        = '0;
        exeBus.pc     = exeIn.pc;
        exeBus.instr  = exeIn.instr;
        exeBus.aluOut = aluOut;
        exeBus.outB   = outB;
        exeBus.except = exceptOut;

        case (exeIn.wbSel)
            wbAluOut: exeBus.result = aluOut;
            wbOutB:   exeBus.result = outB;
            default:  exeBus.result = exeIn.pc + 32'd8;   // link address
        endcase

        case (exeIn.dstSel)
            dstRt:   exeBus.dst = exeIn.rt;
            dstLink: exeBus.dst = linkReg;
            default: exeBus.dst = exeIn.rd;
        endcase

        // commit nothing behind an exception further down
        exeBus.regsWr = exeDisWr ? '0 : exeIn.regsWr;
        exeBus.load   = exeDisWr ? ldNone : exeIn.load;
        exeBus.store  = exeDisWr ? stNone : exeIn.store;
    end

endmodule

// ==== src/hiLo.sv ====
// HI/LO register pair
// Loaded by multiply/divide completion or by mthi/mtlo
module hiLo import exePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        done,
    input  regsWrT      regsWr,
    input  logic        disWr,
    input  logic [31:0] busA,
    input  logic [31:0] hiIn,
    input  logic [31:0] loIn,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hi <= '0;
            lo <= '0;
        end else if (!disWr) begin      // later stage holds an exception
            if (done) begin
                hi <= hiIn;             // remainder or product high
                lo <= loIn;
            end else begin
                if (regsWr.hi) hi <= busA;
                if (regsWr.lo) lo <= busA;
            end
        end
    end

endmodule

// ==== src/mulDiv.sv ====
// Iterative multiply/divide unit
// Radix-2 shift-add multiply and restoring divide on magnitudes over
// 32 steps, stalling the pipeline until the result is ready
module mulDiv import exePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        exeWr,
    input  logic        exeFlush,
    input  idExeT       exeIn,
    output logic        mulDivStall,
    output logic        done,
    output logic [31:0] hiOut,
    output logic [31:0] loOut
);

    typedef enum logic [1:0] {mdIdle, mdBusy, mdFinished} mdStateT;

    mdStateT     state;
    logic [5:0]  count;
    logic [63:0] acc;        // {hi half, lo half} working register
    logic [63:0] stepIn;
    logic [63:0] nextAcc;
    logic [63:0] prodFix;
    logic [31:0] opReg;      // multiplicand or divisor magnitude
    logic [31:0] stepOp;
    logic [31:0] magA;
    logic [31:0] magB;
    logic [32:0] mulSum;
    logic [32:0] top;
    logic [33:0] diff;
    logic        isMulDiv;
    logic        isSigned;
    logic        opDiv;
    logic        divNow;
    logic        isDiv;
    logic        negHi;
    logic        negLo;
    logic        starting;

    assign isMulDiv = exeIn.aluOp inside {aluMult, aluMultu, aluDiv, aluDivu};
    assign isSigned = exeIn.aluOp inside {aluMult, aluDiv};
    assign opDiv    = exeIn.aluOp inside {aluDiv, aluDivu};
    assign magA     = (isSigned && exeIn.busA[31]) ? -exeIn.busA : exeIn.busA;
    assign magB     = (isSigned && exeIn.busB[31]) ? -exeIn.busB : exeIn.busB;
    assign starting = (state == mdIdle);

    // first step runs on the start edge straight from the operands
    assign divNow = starting ? opDiv : isDiv;
    assign stepOp = starting ? (opDiv ? magB : magA) : opReg;
    assign stepIn = starting ? {32'b0, (opDiv ? magA : magB)} : acc;

    always_comb begin
        mulSum = {1'b0, stepIn[63:32]} + (stepIn[0] ? {1'b0, stepOp} : 33'b0);
        top    = stepIn[63:31];                        // remainder shifted left
        diff   = {1'b0, top} - {2'b0, stepOp};
        if (!divNow) begin
            nextAcc = {mulSum, stepIn[31:1]};
        end else if (diff[33]) begin
            nextAcc = {top[31:0], stepIn[30:0], 1'b0};   // restore
        end else begin
            nextAcc = {diff[31:0], stepIn[30:0], 1'b1};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= mdIdle;
            count <= '0;
        end else if (exeFlush || exeWr) begin   // abort or new instruction
            state <= mdIdle;
            count <= '0;
        end else begin
            case (state)
                mdIdle: if (isMulDiv) begin
                    state <= mdBusy;
                    count <= 6'd1;
                end
                mdBusy: if (count == 6'd32) begin
                    state <= mdFinished;
                end else begin
                    count <= count + 6'd1;
                end
                default: ;   // hold until the register reloads
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (starting || (state == mdBusy && count != 6'd32)) begin
            acc <= nextAcc;
        end
        if (starting) begin
            opReg <= stepOp;
            isDiv <= opDiv;
            negHi <= isSigned && exeIn.busA[31];   // remainder sign
            negLo <= isSigned && (exeIn.busA[31] ^ exeIn.busB[31]);
        end
    end

    // remainder takes the sign of the dividend
    assign prodFix = negLo ? -acc : acc;
    assign hiOut   = isDiv ? (negHi ? -acc[63:32] : acc[63:32]) : prodFix[63:32];
    assign loOut   = isDiv ? (negLo ? -acc[31:0] : acc[31:0]) : prodFix[31:0];

    assign done        = (state == mdBusy) && (count == 6'd32) && !exeFlush;
    assign mulDivStall = (starting && isMulDiv) || (state == mdBusy);

endmodule

// ==== testbench/tbExeStage.sv ====
// Execute stage testbench
// Directed tests for the ALU, branches, multiply/divide, HI/LO, exceptions
// and flush that compare the stage against a small reference model
module tbExeStage import exePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic   clk;
    logic   arstN;
    logic   exeWr;
    logic   exeFlush;
    logic   exeDisWr;
    idExeT  idBus;
    exeMemT exeBus;
    logic   branchFlush;
    logic   mulDivStall;
    logic [31:0] rngState = 32'h7e9a9813;

    exeStage i_exeStage (
        .clk, .arstN, .exeWr, .exeFlush, .exeDisWr, .idBus,
        .exeBus, .branchFlush, .mulDivStall
    );

    always #5 clk = ~clk;   // 10 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // reference model of the ALU operations
    function automatic logic [31:0] aluModel(aluOpT op, logic [31:0] a, logic [31:0] b);
        case (op)
            aluAdd, aluAddu: return a + b;
            aluSub, aluSubu: return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluNor:  return ~(a | b);
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu: return (a < b) ? 32'd1 : 32'd0;
            aluSll:  return b << a[4:0];
            aluSrl:  return b >> a[4:0];
            aluSra:  return $signed(b) >>> a[4:0];
            aluLui:  return {b[15:0], 16'h0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic ovfModel(aluOpT op, logic [31:0] a, logic [31:0] b);
        logic signed [32:0] wide;
        wide = (op == aluSub) ? $signed({a[31], a}) - $signed({b[31], b})
                              : $signed({a[31], a}) + $signed({b[31], b});
        return (op inside {aluAdd, aluSub}) && (wide[32] != wide[31]);
    endfunction

    function automatic logic branchModel(branchT br, logic [31:0] a, logic [31:0] b);
        case (br)
            brEq:    return a == b;
            brNe:    return a != b;
            brLez:   return $signed(a) <= 0;
            brGtz:   return $signed(a) > 0;
            brLtz:   return $signed(a) < 0;
            brGez:   return $signed(a) >= 0;
            brJump:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // {hi, lo} after a multiply or divide
    function automatic logic [63:0] mulDivModel(aluOpT op, logic [31:0] a, logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] q;
        logic signed [31:0] r;
        sa = $signed({{32{a[31]}}, a});
        sb = $signed({{32{b[31]}}, b});
        q  = $signed(a) / $signed(b);
        r  = $signed(a) % $signed(b);   // sign of the dividend
        case (op)
            aluMult:  return sa * sb;
            aluMultu: return {32'b0, a} * {32'b0, b};
            aluDiv:   return {r, q};
            default:  return {a % b, a / b};
        endcase
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkWord(input string name, input logic [dataWidth-1:0] expVal,
                             input logic [dataWidth-1:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("error %s: expected %h, actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkExcept(input string name, input exceptT expVal, input exceptT actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("error %s: expected %b, actual %b", name, expVal, actVal));
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("error %s: expected %b, actual %b", name, expVal, actVal));
        end
    endtask

    task automatic checkDst(input string name, input logic [regAddrWidth-1:0] expVal,
                            input logic [regAddrWidth-1:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("error %s: expected %0d, actual %0d", name, expVal, actVal));
        end
    endtask

    // loads one instruction and returns once the outputs are valid
    task automatic issue(input idExeT d);
        @(posedge clk);
        #1;
        idBus = d;
        exeWr = 1'b1;
        @(posedge clk);
        #1;
        exeWr = 1'b0;
    endtask

    task automatic flushStage();
        @(posedge clk);
        #1;
        exeFlush = 1'b1;
        @(posedge clk);
        #1;
        exeFlush = 1'b0;
    endtask

    task automatic waitStallLow(output int cycles);
        cycles = 0;
        while (mulDivStall) begin
            if (cycles == 100) begin
                failRun("mulDivStall stayed high for 100 cycles");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic readHiLo(output logic [31:0] hiVal, output logic [31:0] loVal);
        idExeT d;
        d = idBubble;
        d.readSel    = rdHi;   // mfhi
        d.wbSel      = wbOutB;
        d.regsWr.gpr = 1'b1;
        issue(d);
        hiVal = exeBus.result;
        d.readSel = rdLo;      // mflo
        issue(d);
        loVal = exeBus.result;
    endtask

    task automatic checkBubble(input string name);
        checkBit({name, " writes"}, 1'b0, |exeBus.regsWr);
        checkBit({name, " store"}, 1'b0, exeBus.store != stNone);
        checkBit({name, " branch"}, 1'b0, branchFlush);
        checkBit({name, " stall"}, 1'b0, mulDivStall);
    endtask

    task automatic testAlu();
        idExeT d;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] expAlu;
        logic [4:0]  expDst;
        for (int k = int'(aluAdd); k <= int'(aluLui); k++) begin
            for (int s = 0; s < 4; s++) begin
                d = idBubble;
                d.aluOp      = aluOpT'(5'(k));
                d.pc         = nextRandom();
                d.instr      = nextRandom();
                d.busA       = nextRandom();
                d.busB       = nextRandom();
                d.imm32      = nextRandom();
                d.rt         = d.instr[20:16];
                d.rd         = d.instr[15:11];
                d.aluSrcA    = s[0];
                d.aluSrcB    = s[1];
                d.dstSel     = dstSelT'(2'((k + s) % 3));
                d.wbSel      = wbAluOut;
                d.regsWr.gpr = 1'b1;
                issue(d);
                opA = s[0] ? {27'b0, d.instr[10:6]} : d.busA;
                opB = s[1] ? d.imm32 : d.busB;
                expAlu = aluModel(d.aluOp, opA, opB);
                expDst = (d.dstSel == dstRd) ? d.rd : (d.dstSel == dstRt) ? d.rt : 5'd31;
                checkWord($sformatf("alu op %0d src %0d", k, s), expAlu, exeBus.result);
                checkWord($sformatf("aluOut op %0d src %0d", k, s), expAlu, exeBus.aluOut);
                checkWord($sformatf("outB op %0d src %0d", k, s), d.busB, exeBus.outB);
                checkWord($sformatf("pc op %0d src %0d", k, s), d.pc, exeBus.pc);
                checkWord($sformatf("instr op %0d src %0d", k, s), d.instr, exeBus.instr);
                checkBit($sformatf("gpr write op %0d src %0d", k, s), 1'b1,
                         exeBus.regsWr.gpr);
                checkDst($sformatf("dst op %0d src %0d", k, s), expDst, exeBus.dst);
            end
        end
        d = idBubble;   // jal
        d.pc         = nextRandom();
        d.branch     = brJump;
        d.dstSel     = dstLink;
        d.wbSel      = wbPcPlus8;
        d.regsWr.gpr = 1'b1;
        issue(d);
        checkWord("jal result", d.pc + 32'd8, exeBus.result);
        checkDst("jal dst", 5'd31, exeBus.dst);
        checkBit("jal flush", 1'b1, branchFlush);
    endtask

    task automatic testBranch();
        idExeT d;
        logic [31:0] pairA [5];
        logic [31:0] pairB [5];
        // equal, unequal, negative, zero, positive
        pairA = '{32'd5, 32'd5, 32'hffff_fffd, 32'd0, 32'd9};
        pairB = '{32'd5, 32'd7, 32'd4, 32'd0, 32'h8000_0000};
        for (int br = 0; br < 8; br++) begin
            for (int p = 0; p < 5; p++) begin
                d = idBubble;
                d.branch = branchT'(3'(br));
                d.busA   = pairA[p];
                d.busB   = pairB[p];
                issue(d);
                checkBit($sformatf("branch %0d pair %0d", br, p),
                         branchModel(d.branch, d.busA, d.busB), branchFlush);
            end
        end
    endtask

    task automatic testMulDiv();
        idExeT d;
        aluOpT ops [4];
        logic [63:0] expHL;
        logic [31:0] gotHi;
        logic [31:0] gotLo;
        int cycles;
        ops = '{aluMult, aluMultu, aluDiv, aluDivu};
        for (int k = 0; k < 12; k++) begin
            d = idBubble;
            d.aluOp = ops[k % 4];
            d.busA  = nextRandom();
            d.busB  = $signed(nextRandom()) >>> (k / 4 * 12);   // smaller divisors later
            if (d.busB == '0 || d.busB == '1) begin
                d.busB = 32'd7;   // stay clear of unspecified quotients
            end
            expHL = mulDivModel(d.aluOp, d.busA, d.busB);
            issue(d);
            waitStallLow(cycles);
            checkWord($sformatf("muldiv %0d stall cycles", k), 32'd33, 32'(cycles));
            repeat (3) begin
                @(posedge clk);
                #1;
                checkBit($sformatf("muldiv %0d restart", k), 1'b0, mulDivStall);
            end
            readHiLo(gotHi, gotLo);
            checkWord($sformatf("muldiv %0d hi", k), expHL[63:32], gotHi);
            checkWord($sformatf("muldiv %0d lo", k), expHL[31:0], gotLo);
        end
    endtask

    task automatic testHiLo();
        idExeT d;
        logic [31:0] newHi;
        logic [31:0] newLo;
        logic [31:0] hiVal;
        logic [31:0] loVal;
        newHi = nextRandom();
        newLo = nextRandom();
        d = idBubble;
        d.busA      = newHi;   // mthi
        d.regsWr.hi = 1'b1;
        issue(d);
        d = idBubble;
        d.busA      = newLo;   // mtlo
        d.regsWr.lo = 1'b1;
        issue(d);
        readHiLo(hiVal, loVal);
        checkWord("mthi", newHi, hiVal);
        checkWord("mtlo", newLo, loVal);
        d = idBubble;
        d.busA   = nextRandom();
        d.regsWr = '1;
        d.load   = ldWord;
        d.store  = stWord;
        exeDisWr = 1'b1;
        issue(d);
        checkBit("disWr regsWr", 1'b0, |exeBus.regsWr);
        checkBit("disWr load", 1'b0, exeBus.load != ldNone);
        checkBit("disWr store", 1'b0, exeBus.store != stNone);
        issue(idBubble);   // move leaves before the disable drops
        exeDisWr = 1'b0;
        readHiLo(hiVal, loVal);
        checkWord("hi under disWr", newHi, hiVal);
        checkWord("lo under disWr", newLo, loVal);
    endtask

    task automatic testExcept();
        idExeT d;
        exceptT expEx;
        aluOpT ops [4];
        logic [31:0] pairA [4];
        logic [31:0] pairB [4];
        int size;
        logic bad;
        ops   = '{aluAdd, aluSub, aluAddu, aluSubu};
        pairA = '{32'h7fff_ffff, 32'h8000_0000, 32'd5, 32'h8000_0000};
        pairB = '{32'd1, 32'hffff_ffff, 32'd9, 32'd1};
        for (int k = 0; k < 16; k++) begin
            d = idBubble;
            d.aluOp = ops[k / 4];
            d.busA  = pairA[k % 4];
            d.busB  = pairB[k % 4];
            issue(d);
            expEx = '0;
            expEx.overflow = ovfModel(d.aluOp, d.busA, d.busB);
            checkExcept($sformatf("overflow %0d", k), expEx, exeBus.except);
        end
        for (int kind = 0; kind < 6; kind++) begin   // loads then stores
            for (int low = 0; low < 4; low++) begin
                size = kind % 3 + 1;   // byte, half, word
                d = idBubble;
                d.aluOp   = aluAddu;
                d.aluSrcB = 1'b1;
                d.busA    = nextRandom() & 32'hffff_fffc;
                d.imm32   = 32'(low);
                if (kind < 3) begin
                    d.load = loadT'(2'(size));
                end else begin
                    d.store = storeT'(2'(size));
                end
                bad = (size == 3) ? (low != 0) : ((size == 2) ? low[0] : 1'b0);
                expEx = '0;
                expEx.loadAddr  = (kind < 3) && bad;
                expEx.storeAddr = (kind >= 3) && bad;
                issue(d);
                checkExcept($sformatf("align kind %0d low %0d", kind, low), expEx,
                            exeBus.except);
                checkBit($sformatf("load kind %0d low %0d", kind, low), 1'b1,
                         exeBus.load == d.load);
                checkBit($sformatf("store kind %0d low %0d", kind, low), 1'b1,
                         exeBus.store == d.store);
            end
        end
        for (int f = 1; f < 8; f++) begin
            d = idBubble;
            d.except = exceptT'({3'(f), 3'b000});   // rsvd, syscall, break
            issue(d);
            checkExcept($sformatf("decode flags %0d", f), d.except, exeBus.except);
        end
    endtask

    task automatic testFlush();
        idExeT d;
        logic [31:0] oldHi;
        logic [31:0] oldLo;
        logic [31:0] hiVal;
        logic [31:0] loVal;
        readHiLo(oldHi, oldLo);
        d = idBubble;
        d.branch     = brJump;
        d.regsWr.gpr = 1'b1;
        d.store      = stWord;
        issue(d);
        checkBit("jump before flush", 1'b1, branchFlush);
        flushStage();
        checkBubble("flush jump");
        d = idBubble;
        d.aluOp = aluDiv;
        d.busA  = nextRandom();
        d.busB  = 32'd3;
        issue(d);
        repeat (5) begin
            @(posedge clk);
            #1;
            checkBit("divide running", 1'b1, mulDivStall);
        end
        flushStage();   // abort mid divide
        checkBubble("flush divide");
        repeat (40) begin
            @(posedge clk);
            #1;
            checkBit("stall after flush", 1'b0, mulDivStall);
        end
        readHiLo(hiVal, loVal);
        checkWord("hi after flush", oldHi, hiVal);
        checkWord("lo after flush", oldLo, loVal);
    endtask

    initial begin
        logic [31:0] hiVal;
        logic [31:0] loVal;
        clk      = 1'b0;
        arstN    = 1'b0;
        exeWr    = 1'b0;
        exeFlush = 1'b0;
        exeDisWr = 1'b0;
        idBus    = idBubble;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkBit("reset stall", 1'b0, mulDivStall);
        checkBit("reset branch", 1'b0, branchFlush);
        readHiLo(hiVal, loVal);
        checkWord("reset hi", 32'h0, hiVal);
        checkWord("reset lo", 32'h0, loVal);
        testAlu();
        testBranch();
        testMulDiv();
        testHiLo();
        testExcept();
        testFlush();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
